/* flash_spi_reader.f */
+incdir+logic
logic/spi_cmd_pkg.sv
logic/spi_ctrl_pkg.sv
logic/spi_bit_timer.sv
logic/spi_shifter.sv
logic/spi_sequencer.sv
logic/flash_spi_reader.sv
tests/flash_spi_reader_sva.sv
tests/flash_spi_reader_check.sv
tests/flash_spi_reader_tb.sv

/* tests/flash_spi_reader_tb.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module flash_spi_reader_tb;

   import spi_ctrl_pkg::*;

   localparam int NUM_TESTS  = 20;
   localparam int WAIT_LIMIT = 4000;  // cycles, one transaction needs about 800

   logic                      clk;
   logic                      reset;
   logic                      addr_en;
   logic [`SPI_ADDR_BITS-1:0] addr_data;
   logic                      addr_buffer_free;
   logic                      rd_ack;
   rd_result_t                rd_result;
   logic                      spi_sck;
   logic                      spi_ss;
   logic                      spi_mosi;
   logic                      spi_miso;

   logic [31:0]               seed;
   logic                      timed_out;
   logic [`SPI_ADDR_BITS-1:0] exp_addr;
   int                        tests_done;
   int                        error_count;
   int                        total_errs;

   // flash model, plus the log of the last closed select window
   logic [7:0]                m_op;
   logic [`SPI_ADDR_BITS-1:0] m_addr;
   logic [`SPI_DATA_BITS-1:0] m_word;
   int                        m_bits;
   int                        log_count;
   logic [7:0]                log_op;
   int                        log_bits;
   logic [`SPI_ADDR_BITS-1:0] log_addr;

   flash_spi_reader uut (
      .clk              (clk),
      .reset            (reset),
      .addr_en          (addr_en),
      .addr_data        (addr_data),
      .addr_buffer_free (addr_buffer_free),
      .rd_ack           (rd_ack),
      .rd_result        (rd_result),
      .spi_sck          (spi_sck),
      .spi_ss           (spi_ss),
      .spi_mosi         (spi_mosi),
      .spi_miso         (spi_miso)
   );

   flash_spi_reader_check u_check (
      .clk              (clk),
      .reset            (reset),
      .spi_sck          (spi_sck),
      .spi_ss           (spi_ss),
      .addr_buffer_free (addr_buffer_free),
      .rd_result        (rd_result),
      .exp_addr         (exp_addr),
      .log_count        (log_count),
      .log_op           (log_op),
      .log_bits         (log_bits),
      .log_addr         (log_addr),
      .tests_done       (tests_done),
      .error_count      (error_count)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // flash contents as a function of the address
   function automatic logic [`SPI_DATA_BITS-1:0] flash_word(input logic [`SPI_ADDR_BITS-1:0] a);
      return {8'h00, a} ^ 32'hA5C3_0F1E;
   endfunction

   always @(negedge spi_ss) begin
      m_bits = 0;
      m_op   = '0;
      m_addr = '0;
   end

   always @(posedge spi_sck) begin
      if (!spi_ss) begin
         if (m_bits < 8) begin
            m_op = {m_op[6:0], spi_mosi};
         end else if (m_bits < 32) begin
            m_addr = {m_addr[`SPI_ADDR_BITS-2:0], spi_mosi};
         end
         m_bits = m_bits + 1;
      end
   end

   // read data leaves MSB first, one bit per falling edge after the address
   always @(negedge spi_sck) begin
      if (!spi_ss && m_op == 8'h02 && m_bits >= 32 && m_bits < 64) begin
         m_word   = flash_word(m_addr);
         spi_miso <= m_word[63 - m_bits];
      end
   end

   always @(posedge spi_ss) begin
      if (!reset) begin
         log_op    = m_op;
         log_bits  = m_bits;
         log_addr  = m_addr;
         log_count = log_count + 1;
      end
   end

   task automatic wait_level(input bit on_free, input logic level, input string what);
      int   n;
      logic cur;
      n   = 0;
      cur = on_free ? addr_buffer_free : rd_result.valid;
      while (cur !== level && !timed_out) begin
         @(posedge clk);
         #2;
         n++;
         cur = on_free ? addr_buffer_free : rd_result.valid;
         if (cur !== level && n >= WAIT_LIMIT) begin
            $display("timeout waiting for %s", what);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic run_read();
      logic [31:0] r;
      int          hold;
      wait_level(1'b1, 1'b1, "addr_buffer_free to rise");
      if (timed_out) return;
      r         = next_rand();
      exp_addr  = r[`SPI_ADDR_BITS-1:0];
      addr_data = r[`SPI_ADDR_BITS-1:0];
      addr_en   = 1'b1;
      @(posedge clk);
      #2;
      addr_en = 1'b0;
      wait_level(1'b0, 1'b1, "the result valid level to rise");
      if (timed_out) return;
      r    = next_rand();
      hold = 2 + int'(r[3:0]);
      repeat (hold) begin  // random strobes while the result is held
         @(posedge clk);
         #2;
         r         = next_rand();
         addr_en   = r[0];
         addr_data = r[31:8];
      end
      @(posedge clk);
      #2;
      addr_en = 1'b0;
      rd_ack  = 1'b1;
      @(posedge clk);
      #2;
      rd_ack = 1'b0;
      wait_level(1'b0, 1'b0, "the result valid level to fall");
   endtask

   initial begin
      reset     = 1'b1;
      addr_en   = 1'b0;
      addr_data = '0;
      rd_ack    = 1'b0;
      spi_miso  = 1'b0;
      exp_addr  = '0;
      seed      = 32'h5898_c55d;
      timed_out = 1'b0;
      m_bits    = 0;
      log_count = 0;
      log_op    = '0;
      log_bits  = 0;
      log_addr  = '0;
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;
      repeat (2) @(posedge clk);
      #2;
      for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
         run_read();
      end
      repeat (4) @(posedge clk);
      total_errs = error_count + uut.u_sva.fail_count + (timed_out ? 1 : 0);
      if (tests_done != NUM_TESTS + 1) begin
         $display("only %0d of %0d tests finished", tests_done, NUM_TESTS + 1);
         total_errs++;
      end
      $display("tests %0d, errors %0d", tests_done, total_errs);
      if (total_errs == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* tests/flash_spi_reader_check.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module flash_spi_reader_check (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      spi_sck,
   input  logic                      spi_ss,
   input  logic                      addr_buffer_free,
   input  spi_ctrl_pkg::rd_result_t  rd_result,
   input  logic [`SPI_ADDR_BITS-1:0] exp_addr,
   input  int                        log_count,
   input  logic [7:0]                log_op,
   input  int                        log_bits,
   input  logic [`SPI_ADDR_BITS-1:0] log_addr,
   output int                        tests_done,
   output int                        error_count
);

   int                        seen_logs;
   int                        window;      // 0 wake, 1 write enable, 2 access
   int                        test_errs;
   bit                        idle_checked;
   bit                        valid_q;
   bit                        hold_flagged;
   logic [`SPI_ADDR_BITS-1:0] test_addr;

   function automatic logic [7:0] window_opcode(input int idx);
      return (idx == 0) ? 8'hAB : (idx == 1) ? 8'h06 : 8'h02;
   endfunction

   // access window carries opcode, address and data in one select
   function automatic int window_bits(input int idx);
      return (idx == 2) ? 64 : 8;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         error_count++;
         test_errs++;
      end
   endtask

   task automatic complain(input string what);
      $display("%s", what);
      error_count++;
      test_errs++;
   endtask

   task automatic report(input string name);
      if (test_errs == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d error(s)", name, test_errs);
      end
      tests_done++;
      test_errs = 0;
   endtask

   initial begin
      tests_done   = 0;
      error_count  = 0;
      seen_logs    = 0;
      window       = 0;
      test_errs    = 0;
      idle_checked = 1'b0;
      valid_q      = 1'b0;
      hold_flagged = 1'b0;
      test_addr    = '0;
   end

   always @(posedge clk) begin
      if (!reset && !idle_checked) begin
         compare("spi_ss", spi_ss, 1'b1);
         compare("spi_sck", spi_sck, 1'b0);
         compare("rd_result.valid", rd_result.valid, 1'b0);
         compare("addr_buffer_free", addr_buffer_free, 1'b1);
         report("test 0 idle after reset");
         idle_checked = 1'b1;
      end else if (!reset) begin
         if (log_count != seen_logs) begin  // a select window just closed
            seen_logs = log_count;
            compare("frame opcode", log_op, window_opcode(window));
            compare("frame bits", log_bits, window_bits(window));
            if (window == 2) begin
               compare("frame address", log_addr, exp_addr);
            end
            window = (window == 2) ? 0 : window + 1;
         end
         if (rd_result.valid && !valid_q) begin
            test_addr = exp_addr;
            if (window != 0) begin
               complain("result arrived before the three command windows had ended");
            end
            compare("rd_result.data", rd_result.data, {8'h00, exp_addr} ^ 32'hA5C3_0F1E);
         end
         if (rd_result.valid && addr_buffer_free && !hold_flagged) begin
            complain("addr_buffer_free went high while a result was still held");
            hold_flagged = 1'b1;
         end
         if (!rd_result.valid && valid_q) begin
            report($sformatf("test %0d addr %h", tests_done, test_addr));
            hold_flagged = 1'b0;
         end
         valid_q = rd_result.valid;
      end
   end

endmodule

/* tests/flash_spi_reader_sva.sv */
`timescale 1ns/1ps

module flash_spi_reader_sva (
   input logic                     clk,
   input logic                     reset,
   input logic                     spi_sck,
   input logic                     spi_ss,
   input logic                     spi_mosi,
   input logic                     rd_ack,
   input spi_ctrl_pkg::rd_result_t rd_result
);

   int fail_count = 0;

   // no clock toward the flash outside a select window
   sck_low_deselected: assert property (@(posedge clk) disable iff (reset)
      spi_ss |-> !spi_sck)
      else begin
         fail_count = fail_count + 1;
         $error("spi_sck high while spi_ss is high");
      end

   mosi_stable_high: assert property (@(posedge clk) disable iff (reset)
      spi_sck |-> $stable(spi_mosi))  // mosi only moves in the low half
      else begin
         fail_count = fail_count + 1;
         $error("spi_mosi changed while spi_sck was high");
      end

   // valid drops exactly one cycle after the acknowledge
   valid_fall_on_ack: assert property (@(posedge clk) disable iff (reset)
      $fell(rd_result.valid) |-> $past(rd_ack))
      else begin
         fail_count = fail_count + 1;
         $error("result valid fell without an acknowledge");
      end

   valid_ack_release: assert property (@(posedge clk) disable iff (reset)
      rd_result.valid && rd_ack |=> !rd_result.valid)
      else begin
         fail_count = fail_count + 1;
         $error("result valid still high after an acknowledge");
      end

endmodule

bind flash_spi_reader flash_spi_reader_sva u_sva (.*);

/* logic/flash_spi_reader.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module flash_spi_reader (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      addr_en,
   input  logic [`SPI_ADDR_BITS-1:0] addr_data,
   output logic                      addr_buffer_free,
   input  logic                      rd_ack,
   output spi_ctrl_pkg::rd_result_t  rd_result,
   output logic                      spi_sck,
   output logic                      spi_ss,
   output logic                      spi_mosi,
   input  logic                      spi_miso
);

   import spi_cmd_pkg::*;

   frame_req_t                 req;
   logic                       frame_run;
   logic                       frame_done;
   logic                       wait_start;
   logic                       wait_done;
   logic [`SPI_PHASE_BITS-1:0] bit_phase;
   logic                       bit_shift;
   logic [`SPI_DATA_BITS-1:0]  rx_data;

   spi_sequencer u_seq (
      .clk              (clk),
      .reset            (reset),
      .addr_en          (addr_en),
      .addr_data        (addr_data),
      .rd_ack           (rd_ack),
      .frame_done       (frame_done),
      .wait_done        (wait_done),
      .rx_data          (rx_data),
      .addr_buffer_free (addr_buffer_free),
      .req              (req),
      .frame_run        (frame_run),
      .wait_start       (wait_start),
      .spi_ss           (spi_ss),
      .rd_result        (rd_result)
   );

   spi_bit_timer u_timer (
      .clk        (clk),
      .reset      (reset),
      .frame_run  (frame_run),
      .frame_bits (req.len),  // length holds for the whole frame
      .wait_start (wait_start),
      .bit_phase  (bit_phase),
      .bit_shift  (bit_shift),
      .frame_done (frame_done),
      .wait_done  (wait_done),
      .spi_sck    (spi_sck)
   );

   spi_shifter u_shift (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .bit_phase (bit_phase),
      .bit_shift (bit_shift),
      .spi_miso  (spi_miso),
      .spi_mosi  (spi_mosi),
      .rx_data   (rx_data)
   );

endmodule

/* logic/spi_sequencer.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_sequencer (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      addr_en,
   input  logic [`SPI_ADDR_BITS-1:0] addr_data,
   input  logic                      rd_ack,
   input  logic                      frame_done,
   input  logic                      wait_done,
   input  logic [`SPI_DATA_BITS-1:0] rx_data,
   output logic                      addr_buffer_free,
   output spi_cmd_pkg::frame_req_t   req,
   output logic                      frame_run,
   output logic                      wait_start,
   output logic                      spi_ss,
   output spi_ctrl_pkg::rd_result_t  rd_result
);

   import spi_cmd_pkg::*;
   import spi_ctrl_pkg::*;

   localparam frame_len_t OP_LEN   = frame_len_t'(`SPI_OP_BITS);
   localparam frame_len_t ADDR_LEN = frame_len_t'(`SPI_ADDR_BITS);
   localparam frame_len_t DATA_LEN = frame_len_t'(`SPI_DATA_BITS);

   seq_state_t                state;
   logic [`SPI_ADDR_BITS-1:0] addr_q;
   logic                      rd_valid;
   logic [`SPI_DATA_BITS-1:0] rd_data;

   function automatic frame_req_t make_frame(input logic [`SPI_ADDR_BITS-1:0] payload,
                                             input frame_len_t len,
                                             input logic rx);
      frame_req_t f;
      f.start   = 1'b1;
      f.len     = len;
      f.rx      = rx;
      f.payload = payload;
      return f;
   endfunction

   // opcode goes out first, so it takes the top byte
   function automatic frame_req_t op_frame(input spi_opcode_t op);
      logic [`SPI_ADDR_BITS-1:0] payload;
      payload = {op, {(`SPI_ADDR_BITS - `SPI_OP_BITS){1'b0}}};
      return make_frame(payload, OP_LEN, 1'b0);
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= ST_IDLE;
         req        <= '0;
         frame_run  <= 1'b0;
         wait_start <= 1'b0;
         spi_ss     <= 1'b1;
         rd_valid   <= 1'b0;
      end else begin
         req.start  <= 1'b0;  // pulses, other fields hold for the timer
         wait_start <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (addr_en) begin
                  req       <= op_frame(OP_WAKE);
                  frame_run <= 1'b1;
                  spi_ss    <= 1'b0;
                  state     <= ST_WAKE;
               end
            end
            ST_WAKE, ST_WREN: begin
               if (frame_done) begin
                  frame_run  <= 1'b0;
                  spi_ss     <= 1'b1;  // each opcode gets its own select window
                  wait_start <= 1'b1;
                  state      <= (state == ST_WAKE) ? ST_WAKE_WAIT : ST_WREN_WAIT;
               end
            end
            ST_WAKE_WAIT: begin
               if (wait_done) begin
                  req       <= op_frame(OP_WREN);
                  frame_run <= 1'b1;
                  spi_ss    <= 1'b0;
                  state     <= ST_WREN;
               end
            end
            ST_WREN_WAIT: begin
               if (wait_done) begin
                  req       <= op_frame(OP_ACCESS);
                  frame_run <= 1'b1;
                  spi_ss    <= 1'b0;
                  state     <= ST_CMD;
               end
            end
            ST_CMD: begin
               if (frame_done) begin  // no gap, timer rolls into the next frame
                  req   <= make_frame(addr_q, ADDR_LEN, 1'b0);
                  state <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               if (frame_done) begin
                  req   <= make_frame('0, DATA_LEN, 1'b1);  // mosi idles low while reading
                  state <= ST_READ;
               end
            end
            ST_READ: begin
               if (frame_done) begin
                  frame_run <= 1'b0;
                  spi_ss    <= 1'b1;
                  state     <= ST_HOLD;
               end
            end
            ST_HOLD: begin
               // the last bit lands in rx_data on the frame_done edge, so latch one cycle later
               if (!rd_valid) begin
                  rd_valid <= 1'b1;
               end else if (rd_ack) begin
                  rd_valid <= 1'b0;
                  state    <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // address and result payload
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && addr_en) begin
         addr_q <= addr_data;
      end
      if (state == ST_HOLD && !rd_valid) begin
         rd_data <= rx_data;
      end
   end

   assign addr_buffer_free = (state == ST_IDLE);
   assign rd_result        = '{valid: rd_valid, data: rd_data};

endmodule

/* logic/spi_shifter.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_shifter (
   input  logic                       clk,
   input  logic                       reset,
   input  spi_cmd_pkg::frame_req_t    req,
   input  logic [`SPI_PHASE_BITS-1:0] bit_phase,
   input  logic                       bit_shift,
   input  logic                       spi_miso,
   output logic                       spi_mosi,
   output logic [`SPI_DATA_BITS-1:0]  rx_data
);

   typedef logic [`SPI_PHASE_BITS-1:0] phase_t;

   // late in the high half of sck, after the flash has settled MISO
   localparam phase_t SAMPLE_PHASE = phase_t'(`SPI_CLK_DIV - 2);

   logic [`SPI_ADDR_BITS-1:0] tx_q;
   logic                      rx_en;
   logic                      miso_q;

   // transmit side, MSB of tx_q is the pin
   always_ff @(posedge clk) begin
      if (reset) begin
         tx_q  <= '0;   // keeps mosi low before the first frame
         rx_en <= 1'b0;
      end else if (req.start) begin
         tx_q  <= req.payload;
         rx_en <= req.rx;
      end else if (bit_shift) begin
         tx_q <= {tx_q[`SPI_ADDR_BITS-2:0], tx_q[`SPI_ADDR_BITS-1]};  // rotate left
      end
   end

   assign spi_mosi = tx_q[`SPI_ADDR_BITS-1];

   always_ff @(posedge clk) begin
      if (bit_phase == SAMPLE_PHASE) begin
         miso_q <= spi_miso;
      end
   end

   // receive side, sample enters at the bit boundary
   always_ff @(posedge clk) begin
      if (bit_shift && rx_en) begin
         rx_data <= {rx_data[`SPI_DATA_BITS-2:0], miso_q};
      end
   end

endmodule

/* logic/spi_bit_timer.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_bit_timer (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       frame_run,
   input  logic [`SPI_LEN_BITS-1:0]   frame_bits,
   input  logic                       wait_start,
   output logic [`SPI_PHASE_BITS-1:0] bit_phase,
   output logic                       bit_shift,
   output logic                       frame_done,
   output logic                       wait_done,
   output logic                       spi_sck
);

   typedef logic [`SPI_PHASE_BITS-1:0] phase_t;

   localparam int     WAIT_W     = $clog2(`SPI_WAIT_CYCLES + 1);
   localparam phase_t LAST_PHASE = phase_t'(`SPI_CLK_DIV - 1);
   localparam phase_t HIGH_PHASE = phase_t'(`SPI_CLK_DIV / 2);  // sck rises here

   logic [`SPI_LEN_BITS-1:0] bit_cnt;
   logic [WAIT_W-1:0]        wait_cnt;
   logic                     wait_busy;

   // phase and bit count only move while a frame is on the wire
   always_ff @(posedge clk) begin
      if (reset) begin
         bit_phase <= '0;
         bit_cnt   <= '0;
      end else if (!frame_run) begin
         bit_phase <= '0;
         bit_cnt   <= '0;
      end else begin
         bit_phase <= bit_shift ? '0 : bit_phase + 1'b1;
         if (bit_shift) begin
            bit_cnt <= frame_done ? '0 : bit_cnt + 1'b1;  // back-to-back frames restart at 0
         end
      end
   end

   assign bit_shift  = frame_run && (bit_phase == LAST_PHASE);
   assign frame_done = bit_shift && (bit_cnt == frame_bits - 1'b1);

   // low half first, so sck falls as each new bit begins
   assign spi_sck = (bit_phase >= HIGH_PHASE);

   // recovery wait, counts down to zero
   always_ff @(posedge clk) begin
      if (reset) begin
         wait_busy <= 1'b0;
         wait_cnt  <= '0;
      end else if (wait_start) begin
         wait_busy <= 1'b1;
         wait_cnt  <= WAIT_W'(`SPI_WAIT_CYCLES - 1);
      end else if (wait_busy) begin
         if (wait_cnt == '0) begin
            wait_busy <= 1'b0;
         end else begin
            wait_cnt <= wait_cnt - 1'b1;
         end
      end
   end

   assign wait_done = wait_busy && (wait_cnt == '0);

endmodule

/* logic/spi_ctrl_pkg.sv */
`include "spi_consts.svh"

package spi_ctrl_pkg;

   // access sequence
   typedef enum logic [3:0] {
      ST_IDLE,       // waiting for an address
      ST_WAKE,       // wake-up frame on the wire
      ST_WAKE_WAIT,  // recovery after wake-up
      ST_WREN,       // write-enable frame
      ST_WREN_WAIT,  // recovery after write-enable
      ST_CMD,        // access opcode, chip select stays low from here
      ST_ADDR,       // 24-bit address
      ST_READ,       // 32-bit data shifted in
      ST_HOLD        // result held until the host acknowledges
   } seq_state_t;

   // what the host sees
   typedef struct packed {
      logic                      valid;
      logic [`SPI_DATA_BITS-1:0] data;
   } rd_result_t;

endpackage

/* logic/spi_cmd_pkg.sv */
`include "spi_consts.svh"

package spi_cmd_pkg;

   // flash opcodes used by the access sequence
   typedef enum logic [`SPI_OP_BITS-1:0] {
      OP_WAKE   = 8'hAB,  // release from deep power-down
      OP_WREN   = 8'h06,  // write enable
      OP_ACCESS = 8'h02   // access opcode, address follows
   } spi_opcode_t;

   typedef logic [`SPI_LEN_BITS-1:0] frame_len_t;

   // one frame for the shifter, payload leaves MSB first
   typedef struct packed {
      logic                      start;   // one-cycle pulse
      frame_len_t                len;     // bits in the frame
      logic                      rx;      // capture MISO into rx_data
      logic [`SPI_ADDR_BITS-1:0] payload; // opcodes sit in the top byte
   } frame_req_t;

endpackage

/* logic/spi_consts.svh */
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// SCK timing, system clocks per bit
`define SPI_CLK_DIV     8
`define SPI_PHASE_BITS  3

// recovery time after wake-up and write-enable, cut down for simulation
`define SPI_WAIT_CYCLES 64

`define SPI_OP_BITS     8
`define SPI_ADDR_BITS   24
`define SPI_DATA_BITS   32
`define SPI_LEN_BITS    6   // frame length field, up to 63 bits

`endif
